/* src/route_map_pkg.sv */
package route_map_pkg;

    // segment codes in the top three virtual address bits
    // kseg0 goes through the cache
    localparam logic [2:0] seg_kseg0 = 3'b100;
    // kseg1 always bypasses the cache
    localparam logic [2:0] seg_kseg1 = 3'b101;

    // config register page, upper address half
    // seen through kseg1
    localparam logic [15:0] confreg_page_virt = 16'hbfaf;
    // same page after translation
    localparam logic [15:0] confreg_page_phys = 16'h1faf;

    // low address bits that survive translation
    // the upper three bits of a physical address are zero
    localparam int phys_offset_width = 29;

endpackage

/* src/mem_route_pkg.sv */
package mem_route_pkg;

    // source-order queue, fixed by the two-bit pointers
    localparam int order_depth = 4;

    typedef logic [1:0] ptr_t;

    // downstream port that serves a request
    typedef enum logic {
        path_uncached = 1'b0,
        path_cached   = 1'b1
    } path_t;

    // segment view of a virtual address
    typedef struct packed {
        logic [2:0]                                  code;
        logic [route_map_pkg::phys_offset_width-1:0] offset;
    } seg_view_t;

    // page view, upper half picks out device pages
    typedef struct packed {
        logic [15:0] num;
        logic [15:0] low;
    } page_view_t;

    typedef union packed {
        seg_view_t  seg;
        page_view_t page;
    } vaddr_u;

    // request fields of an sram-like port, req travels apart
    typedef struct packed {
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

endpackage

/* src/addr_decode.sv */
module addr_decode (
    input  mem_route_pkg::vaddr_u vaddr,
    output mem_route_pkg::path_t  path,
    output logic [31:0]           paddr
);

    logic in_kseg0;
    logic on_confreg;

    // only kseg0 is cacheable
    assign in_kseg0 = (vaddr.seg.code == route_map_pkg::seg_kseg0);

    // device registers must never be cached,
    // whichever view the address was formed in
    assign on_confreg = (vaddr.page.num == route_map_pkg::confreg_page_virt)
                     || (vaddr.page.num == route_map_pkg::confreg_page_phys);

    always_comb begin
        if (in_kseg0 && !on_confreg) begin
            path = mem_route_pkg::path_cached;
        end else begin
            path = mem_route_pkg::path_uncached;
        end
    end

    // fixed mapping, segment bits dropped
    assign paddr = {
        {(32 - route_map_pkg::phys_offset_width){1'b0}},
        vaddr.seg.offset
    };

endmodule

/* src/path_issue.sv */
module path_issue (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   cpu_req,
    input  mem_route_pkg::mem_req_t cpu_fields,
    input  mem_route_pkg::path_t   path,
    input  logic [31:0]            paddr,
    output logic                   c_req,
    output logic                   u_req,
    output mem_route_pkg::mem_req_t c_fields,
    output mem_route_pkg::mem_req_t u_fields,
    input  logic                   c_addr_ok,
    input  logic                   u_addr_ok,
    output logic                   cpu_addr_ok,
    output logic                   push,
    output mem_route_pkg::path_t   push_path,
    input  logic                   empty,
    input  logic                   full,
    input  mem_route_pkg::path_t   head_path,
    output logic [15:0]            stall_count
);

    logic                    path_switch;
    logic                    may_issue;
    logic                    to_cache;
    mem_route_pkg::mem_req_t down_fields;

    // outstanding work on the other port blocks a switch
    assign path_switch = !empty && (path != head_path);
    assign may_issue   = !full && !path_switch;
    assign to_cache    = (path == mem_route_pkg::path_cached);

    always_comb begin
        down_fields      = cpu_fields;
        down_fields.addr = paddr;
    end

    assign c_req    = cpu_req && may_issue && to_cache;
    assign u_req    = cpu_req && may_issue && !to_cache;
    assign c_fields = down_fields;
    assign u_fields = down_fields;

    assign cpu_addr_ok = may_issue && (to_cache ? c_addr_ok : u_addr_ok);

    // record the port of every accepted request
    assign push      = cpu_req && cpu_addr_ok;
    assign push_path = path;

    // cycles lost waiting for the other port to drain, saturating
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stall_count <= 16'd0;
        end else if (cpu_req && path_switch && (stall_count != 16'hffff)) begin
            stall_count <= stall_count + 16'd1;
        end
    end

endmodule

/* src/response_merge.sv */
module response_merge (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 push,
    input  mem_route_pkg::path_t push_path,
    input  logic                 c_data_ok,
    input  logic                 u_data_ok,
    input  logic [31:0]          c_rdata,
    input  logic [31:0]          u_rdata,
    output logic [31:0]          cpu_rdata,
    output logic                 cpu_data_ok,
    output logic                 empty,
    output logic                 full,
    output mem_route_pkg::path_t head_path
);

    mem_route_pkg::path_t order_q [mem_route_pkg::order_depth];
    mem_route_pkg::ptr_t  wr_ptr;
    mem_route_pkg::ptr_t  rd_ptr;
    logic [2:0]           count;
    logic                 pop;

    // one completion per cycle at most, issue never mixes ports
    assign pop         = c_data_ok || u_data_ok;
    assign cpu_data_ok = pop;

    assign head_path = order_q[rd_ptr];
    assign cpu_rdata = (head_path == mem_route_pkg::path_cached) ? c_rdata : u_rdata;

    assign empty = (count == 3'd0);
    assign full  = (count == 3'(mem_route_pkg::order_depth));

    // entries need no reset, count guards them
    always_ff @(posedge aclk) begin
        if (push) begin
            order_q[wr_ptr] <= push_path;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            // simultaneous push and pop keeps occupancy
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/mem_route_top.sv */
module mem_route_top (
    input  logic                    aclk,
    input  logic                    aresetn,

    // processor side
    input  logic                    cpu_req,
    input  mem_route_pkg::mem_req_t cpu_fields,
    output logic                    cpu_addr_ok,
    output logic [31:0]             cpu_rdata,
    output logic                    cpu_data_ok,

    // cached port
    output logic                    c_req,
    output mem_route_pkg::mem_req_t c_fields,
    input  logic                    c_addr_ok,
    input  logic [31:0]             c_rdata,
    input  logic                    c_data_ok,

    // uncached port
    output logic                    u_req,
    output mem_route_pkg::mem_req_t u_fields,
    input  logic                    u_addr_ok,
    input  logic [31:0]             u_rdata,
    input  logic                    u_data_ok,

    output logic [15:0]             stall_count
);

    mem_route_pkg::path_t req_path;
    logic [31:0]          req_paddr;
    logic                 push;
    mem_route_pkg::path_t push_path;
    logic                 empty;
    logic                 full;
    mem_route_pkg::path_t head_path;

    addr_decode addr_decode_i (
        .vaddr (cpu_fields.addr),
        .path  (req_path),
        .paddr (req_paddr)
    );

    path_issue path_issue_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .cpu_req     (cpu_req),
        .cpu_fields  (cpu_fields),
        .path        (req_path),
        .paddr       (req_paddr),
        .c_req       (c_req),
        .u_req       (u_req),
        .c_fields    (c_fields),
        .u_fields    (u_fields),
        .c_addr_ok   (c_addr_ok),
        .u_addr_ok   (u_addr_ok),
        .cpu_addr_ok (cpu_addr_ok),
        .push        (push),
        .push_path   (push_path),
        .empty       (empty),
        .full        (full),
        .head_path   (head_path),
        .stall_count (stall_count)
    );

    response_merge response_merge_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .push        (push),
        .push_path   (push_path),
        .c_data_ok   (c_data_ok),
        .u_data_ok   (u_data_ok),
        .c_rdata     (c_rdata),
        .u_rdata     (u_rdata),
        .cpu_rdata   (cpu_rdata),
        .cpu_data_ok (cpu_data_ok),
        .empty       (empty),
        .full        (full),
        .head_path   (head_path)
    );

endmodule

/* test/mem_route_properties.sv */
module mem_route_properties (
    input logic       aclk,
    input logic       aresetn,
    input logic       push,
    input logic       c_data_ok,
    input logic       u_data_ok,
    input logic       empty,
    input logic [2:0] count
);

    // every completion retires an entry that must exist
    pop_needs_entry: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (c_data_ok || u_data_ok) |-> !empty
    ) else $error("order queue popped while empty");

    // occupancy stays within the queue
    push_needs_room: assert property (
        @(posedge aclk) disable iff (!aresetn)
        push |-> (count < mem_route_pkg::order_depth)
    ) else $error("order queue pushed while full");

    // one port drains before the other starts
    one_port_completes: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(c_data_ok && u_data_ok)
    ) else $error("both ports completed in one cycle");

endmodule

bind response_merge mem_route_properties mem_route_properties_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (push),
    .c_data_ok (c_data_ok),
    .u_data_ok (u_data_ok),
    .empty     (empty),
    .count     (count)
);

/* test/tb_mem_route.sv */
module tb_mem_route;

    typedef struct packed {
        logic        is_read;
        logic [31:0] data;
    } expect_t;

    logic                    aclk = 1'b0;
    logic                    aresetn;
    logic                    cpu_req;
    mem_route_pkg::mem_req_t cpu_fields;
    logic                    cpu_addr_ok;
    logic [31:0]             cpu_rdata;
    logic                    cpu_data_ok;
    logic                    c_req;
    mem_route_pkg::mem_req_t c_fields;
    logic                    c_addr_ok = 1'b0;
    logic [31:0]             c_rdata = 32'd0;
    logic                    c_data_ok = 1'b0;
    logic                    u_req;
    mem_route_pkg::mem_req_t u_fields;
    logic                    u_addr_ok = 1'b0;
    logic [31:0]             u_rdata = 32'd0;
    logic                    u_data_ok = 1'b0;
    logic [15:0]             stall_count;

    integer      seed = 35;
    int          errors = 0;
    int          accepted = 0;
    int          completed = 0;
    int          c_out = 0;
    int          u_out = 0;
    int          hold = 0;
    logic [15:0] exp_stalls = 16'd0;
    bit          seen_req = 1'b0;
    bit          timed_out = 1'b0;
    logic [31:0] cmem [64];
    logic [31:0] umem [64];
    logic [31:0] ref_cmem [64];
    logic [31:0] ref_umem [64];
    logic [31:0] cq [$];
    logic [31:0] uq [$];
    expect_t     exp_q [$];

    mem_route_top mem_route_top_i (.*);

    always #10 aclk = ~aclk;

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // cached and uncached memories start with different contents
    function automatic logic [31:0] fill_word(input logic cached, input logic [5:0] idx);
        return {2'b00, idx, 2'b01, ~idx, 2'b10, idx, cached, 1'b1, ~idx};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] wdata,
                                               input logic [3:0]  wstrb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // only kseg0 is cached, and never the config register page
    function automatic mem_route_pkg::path_t route_of(input logic [31:0] vaddr);
        if (vaddr[31:29] == route_map_pkg::seg_kseg0
                && vaddr[31:16] != route_map_pkg::confreg_page_virt
                && vaddr[31:16] != route_map_pkg::confreg_page_phys) begin
            return mem_route_pkg::path_cached;
        end
        return mem_route_pkg::path_uncached;
    endfunction

    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [31:0] low;
        logic [31:0] mid;
        low = {24'd0, r[7:2], 2'b00};
        mid = {8'd0, r[23:16], 16'd0};
        case (r[9:8])
            2'd0:    pick_addr = {route_map_pkg::seg_kseg0, 29'd0} | mid | low;
            2'd1:    pick_addr = {route_map_pkg::seg_kseg1, 29'd0} | mid | low;
            2'd2:    pick_addr = {route_map_pkg::confreg_page_virt, 16'd0} | low;
            default: pick_addr = {route_map_pkg::confreg_page_phys, 16'd0} | low;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    // both downstream memories answer in order from their own FIFOs
    always @(posedge aclk) begin
        logic [31:0] r;
        logic [5:0]  ci;
        logic [5:0]  ui;
        r  = rand32();
        ci = c_fields.addr[7:2];
        ui = u_fields.addr[7:2];
        if (!aresetn) begin
            for (int i = 0; i < 64; i++) begin
                cmem[i] = fill_word(1'b1, 6'(i));
                umem[i] = fill_word(1'b0, 6'(i));
            end
            cq.delete();
            uq.delete();
            hold = 0;
            c_addr_ok <= 1'b0;
            u_addr_ok <= 1'b0;
            c_data_ok <= 1'b0;
            u_data_ok <= 1'b0;
        end else begin
            if (c_data_ok) begin
                void'(cq.pop_front());
            end
            if (u_data_ok) begin
                void'(uq.pop_front());
            end
            if (c_req && c_addr_ok) begin
                cq.push_back(cmem[ci]);
                if (c_fields.wr) begin
                    cmem[ci] = merge_bytes(cmem[ci], c_fields.wdata, c_fields.wstrb);
                end
            end
            if (u_req && u_addr_ok) begin
                uq.push_back(umem[ui]);
                if (u_fields.wr) begin
                    umem[ui] = merge_bytes(umem[ui], u_fields.wdata, u_fields.wstrb);
                end
            end
            // now and then both memories go quiet for a while
            if (hold != 0) begin
                hold--;
            end else if (r[9:4] == 6'd0) begin
                hold = 30;
            end
            c_addr_ok <= (r[1:0] != 2'b00);
            u_addr_ok <= (r[3:2] != 2'b00);
            c_data_ok <= (hold == 0) && (cq.size() != 0) && r[10];
            u_data_ok <= (hold == 0) && (uq.size() != 0) && r[11];
            if (cq.size() != 0) begin
                c_rdata <= cq[0];
            end
            if (uq.size() != 0) begin
                u_rdata <= uq[0];
            end
        end
    end

    // scoreboard with its own copy of both memories
    always @(posedge aclk) begin
        expect_t                 entry;
        mem_route_pkg::mem_req_t want;
        logic [5:0]              idx;
        logic                    hit;
        logic                    switching;
        if (cpu_req) begin
            seen_req = 1'b1;
        end
        if (!seen_req && (c_req || u_req || cpu_data_ok)) begin
            report_error("port active before the first processor request");
        end
        if (!aresetn) begin
            for (int i = 0; i < 64; i++) begin
                ref_cmem[i] = fill_word(1'b1, 6'(i));
                ref_umem[i] = fill_word(1'b0, 6'(i));
            end
            exp_q.delete();
            c_out = 0;
            u_out = 0;
            exp_stalls = 16'd0;
        end else begin
            if (c_data_ok && u_data_ok) begin
                report_error("both ports completed in the same cycle");
            end
            if ((c_req && c_addr_ok && u_out != 0) || (u_req && u_addr_ok && c_out != 0)) begin
                report_error("request accepted while the other port is still busy");
            end
            // a request for the idle port waits while the busy one drains
            switching = (route_of(cpu_fields.addr) == mem_route_pkg::path_cached)
                        ? (u_out != 0) : (c_out != 0);
            if (stall_count !== exp_stalls) begin
                report_error($sformatf("stall count %0d, expected %0d",
                                       stall_count, exp_stalls));
            end
            if (cpu_req && switching && exp_stalls != 16'hffff) begin
                exp_stalls++;
            end
            if (cpu_req && cpu_addr_ok) begin
                want = cpu_fields;
                want.addr = {3'b000, cpu_fields.addr[28:0]};
                idx = cpu_fields.addr[7:2];
                entry.is_read = !cpu_fields.wr;
                if (route_of(cpu_fields.addr) == mem_route_pkg::path_cached) begin
                    hit = c_req && c_addr_ok && !u_req && (c_fields === want);
                    entry.data = ref_cmem[idx];
                    if (cpu_fields.wr) begin
                        ref_cmem[idx] = merge_bytes(ref_cmem[idx], cpu_fields.wdata,
                                                    cpu_fields.wstrb);
                    end
                end else begin
                    hit = u_req && u_addr_ok && !c_req && (u_fields === want);
                    entry.data = ref_umem[idx];
                    if (cpu_fields.wr) begin
                        ref_umem[idx] = merge_bytes(ref_umem[idx], cpu_fields.wdata,
                                                    cpu_fields.wstrb);
                    end
                end
                if (!hit) begin
                    report_error($sformatf("request to %h not forwarded as %h on its port",
                                           cpu_fields.addr, want.addr));
                end
                exp_q.push_back(entry);
                accepted++;
            end else if ((c_req && c_addr_ok) || (u_req && u_addr_ok)) begin
                report_error("downstream acceptance without a processor acceptance");
            end
            if (cpu_data_ok) begin
                if (exp_q.size() == 0) begin
                    report_error("completion with nothing outstanding");
                end else begin
                    entry = exp_q.pop_front();
                    if (entry.is_read && cpu_rdata !== entry.data) begin
                        report_error($sformatf("read data %h, expected %h",
                                               cpu_rdata, entry.data));
                    end
                    completed++;
                end
            end
            if (c_req && c_addr_ok) begin
                c_out++;
            end
            if (u_req && u_addr_ok) begin
                u_out++;
            end
            if (c_data_ok) begin
                c_out--;
            end
            if (u_data_ok) begin
                u_out--;
            end
            if (c_out + u_out > mem_route_pkg::order_depth) begin
                report_error($sformatf("%0d requests in flight", c_out + u_out));
            end
        end
    end

    initial begin
        mem_route_pkg::mem_req_t f;
        logic [31:0]             r;
        int                      waited;
        aresetn    = 1'b0;
        cpu_req    = 1'b0;
        cpu_fields = '0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        // quiet cycles before the first request
        repeat (4) @(posedge aclk);
        for (int n = 0; n < 400; n++) begin
            r = rand32();
            f.wr    = r[24];
            f.size  = r[26:25];
            f.addr  = pick_addr(r);
            f.wdata = rand32();
            f.wstrb = r[30:27];
            cpu_req    <= 1'b1;
            cpu_fields <= f;
            waited = 0;
            do begin
                @(posedge aclk);
                waited++;
            end while (!cpu_addr_ok && waited < 200);
            if (!cpu_addr_ok) begin
                $display("timeout: request %0d was never accepted", n);
                timed_out = 1'b1;
                break;
            end
            if (r[31]) begin
                cpu_req <= 1'b0;
                repeat (r[11:10] + 1) @(posedge aclk);
            end
        end
        cpu_req <= 1'b0;
        waited = 0;
        while (!timed_out && exp_q.size() != 0 && waited < 2000) begin
            @(negedge aclk);
            waited++;
        end
        if (!timed_out && exp_q.size() != 0) begin
            $display("timeout: %0d completions never arrived", exp_q.size());
            timed_out = 1'b1;
        end
        $display("errors %0d, accepted %0d, completed %0d, switch stalls %0d",
                 errors, accepted, completed, stall_count);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/route_map_pkg.sv
src/mem_route_pkg.sv
src/addr_decode.sv
src/path_issue.sv
src/response_merge.sv
src/mem_route_top.sv
test/mem_route_properties.sv
test/tb_mem_route.sv

/* Makefile */
SIM  := obj_dir/Vtb_mem_route
SRCS := $(wildcard src/*.sv test/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

# rebuilt only when a source or the file list changes
$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mem_route -f filelist.f

clean:
	rm -rf obj_dir sim.log
